// ==== hw/hmCodingPkg.sv ====
`default_nettype none

package hmCodingPkg;

	// --------------------------------------------------
	// Baseline JPEG scan constants
	// --------------------------------------------------
	localparam int MaxCodeLength = 16;
	localparam int CoefPerBlock = 64;
	localparam int LastCoef = CoefPerBlock - 1;
	localparam int BlocksPerMcu = 6;	// 4:2:0, Y0..Y3 Cb Cr
	localparam int ZrlRun = 15;

	typedef logic [1:0] tableClass_t;	// [1] chroma, [0] AC
	typedef logic [2:0] blockColor_t;
	typedef logic [$clog2(CoefPerBlock)-1:0] coefIndex_t;
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] symbolIndex_t;

	// Per-symbol decode phases
	typedef enum logic [2:0] {
		DecIdle, DecFetch, DecMatch, DecShift,
		DecLookup, DecValue, DecPredict, DecEmit
	} decodeState_t;

endpackage

`default_nettype wire

// ==== hw/hmDatapathPkg.sv ====
`default_nettype none

package hmDatapathPkg;

	// --------------------------------------------------
	// Datapath widths
	// --------------------------------------------------
	localparam int WindowWidth = 32;
	localparam int CodeWidth = 16;

	// Left-aligned code thresholds share this width
	typedef logic [CodeWidth-1:0] codeWord_t;
	typedef logic [WindowWidth-1:0] bitWindow_t;

	typedef logic [3:0] codeLength_t;	// Matched length minus one
	typedef logic [6:0] useWidth_t;

	// Running DC sum per component
	typedef logic signed [31:0] dcSum_t;

	typedef logic [7:0] quantStep_t;

endpackage

`default_nettype wire

// ==== hw/hmDecodeFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmDecodeFsm import hmCodingPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic DataInRun,
	input wire logic DataInEnable,
	input wire logic DataOutIdle,
	output logic runActive,
	output logic loadStrobe,
	output logic matchStrobe,
	output logic shiftStrobe,
	output logic valueStrobe,
	output logic predictStrobe,
	output logic emitStrobe
);

	decodeState_t state, stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			DecIdle: if (DataInRun) stateNext = DecFetch;
			DecFetch: begin
				if (!DataInRun) begin
					stateNext = DecIdle;
				end else if (DataInEnable && DataOutIdle) begin
					stateNext = DecMatch;
				end
			end
			DecMatch: stateNext = DecShift;
			DecShift: stateNext = DecLookup;
			DecLookup: if (DataOutIdle) stateNext = DecValue;	// DHT read settles here
			DecValue: stateNext = DecPredict;
			DecPredict: stateNext = DecEmit;
			DecEmit: stateNext = DecFetch;
			default: stateNext = DecIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= DecIdle;
		end else begin
			state <= stateNext;
		end
	end

	// --------------------------------------------------
	// Phase strobes
	// --------------------------------------------------
	assign runActive = (state != DecIdle);
	assign loadStrobe = (state == DecFetch) && DataInRun && DataInEnable && DataOutIdle;
	assign matchStrobe = (state == DecMatch);
	assign shiftStrobe = (state == DecShift);
	assign valueStrobe = (state == DecValue);
	assign predictStrobe = (state == DecPredict);	// Source consumes bits here
	assign emitStrobe = (state == DecEmit);

endmodule

`default_nettype wire

// ==== hw/hmCoefCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmCoefCounter import hmCodingPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic runActive,
	input wire logic valueStrobe,
	input wire logic emitStrobe,
	input wire nibble_t DhtZero,
	input wire nibble_t DhtWidth,
	output tableClass_t tableClass,
	output blockColor_t blockColor,
	output coefIndex_t coefIndex,
	output logic coefValid,
	output logic DataOutEnable,
	output blockColor_t DataOutColor
);

	logic lastCoef;

	assign lastCoef = (coefIndex == coefIndex_t'(LastCoef));
	assign tableClass = {blockColor[2], coefIndex != '0};
	assign DataOutEnable = emitStrobe && lastCoef;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			coefIndex <= '0;
			blockColor <= '0;
			coefValid <= 1'b0;
			DataOutColor <= '0;
		end else if (!runActive) begin
			coefIndex <= '0;
			blockColor <= '0;
			coefValid <= 1'b0;
			DataOutColor <= '0;
		end else if (valueStrobe) begin
			if (coefIndex == '0) begin
				coefValid <= 1'b1;	// DC always emits
			end else if (DhtZero == '0 && DhtWidth == '0) begin
				coefIndex <= coefIndex_t'(LastCoef);	// EOB
				coefValid <= 1'b0;
			end else if (DhtZero == nibble_t'(ZrlRun) && DhtWidth == '0) begin
				coefIndex <= coefIndex + coefIndex_t'(ZrlRun);
				coefValid <= 1'b0;
			end else begin
				coefIndex <= coefIndex + {2'b00, DhtZero};
				coefValid <= 1'b1;
			end
		end else if (emitStrobe) begin
			if (lastCoef) begin
				coefIndex <= '0;
				DataOutColor <= blockColor;
				blockColor <= (blockColor == blockColor_t'(BlocksPerMcu - 1)) ?
					'0 : blockColor + 3'd1;
			end else begin
				coefIndex <= coefIndex + 6'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hmCodeTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmCodeTable import hmCodingPkg::*, hmDatapathPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic HuffmanTableEnable,
	input wire tableClass_t HuffmanTableColor,
	input wire codeLength_t HuffmanTableCount,
	input wire codeWord_t HuffmanTableCode,
	input wire symbolIndex_t HuffmanTableStart,
	input wire logic loadStrobe,
	input wire logic matchStrobe,
	input wire logic shiftStrobe,
	input wire tableClass_t tableClass,
	input wire codeWord_t windowTop,
	output codeLength_t codeLength,
	output symbolIndex_t DhtNumber
);

	// --------------------------------------------------
	// Table storage, four classes
	// --------------------------------------------------
	codeWord_t thresholdMem [4][MaxCodeLength];
	symbolIndex_t startMem [4][MaxCodeLength];

	always_ff @(posedge clk) begin
		if (HuffmanTableEnable) begin
			thresholdMem[HuffmanTableColor][HuffmanTableCount] <= HuffmanTableCode;
			startMem[HuffmanTableColor][HuffmanTableCount] <= HuffmanTableStart;
		end
	end

	// Active bank for the current symbol
	codeWord_t bankThreshold [MaxCodeLength];
	symbolIndex_t bankStart [MaxCodeLength];
	logic [MaxCodeLength-1:0] matchBits;

	codeWord_t codeValue;
	codeWord_t codeThreshold;
	symbolIndex_t codeStart;

	always_ff @(posedge clk) begin
		if (loadStrobe) begin
			bankThreshold <= thresholdMem[tableClass];
			bankStart <= startMem[tableClass];
		end
		if (shiftStrobe) begin
			codeValue <= windowTop >> (4'd15 - codeLength);	// Right-aligned code
			codeThreshold <= bankThreshold[codeLength] >> (4'd15 - codeLength);
			codeStart <= bankStart[codeLength];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			matchBits <= '0;
		end else if (matchStrobe) begin
			for (int i = 0; i < MaxCodeLength; i++) begin
				matchBits[i] <= (windowTop >= bankThreshold[i]);
			end
		end
	end

	// Thermometer from the shortest length up
	always_comb begin
		codeLength = '0;
		for (int i = 0; i < MaxCodeLength; i++) begin
			if (matchBits[i]) codeLength = codeLength_t'(i);
		end
	end

	assign DhtNumber = symbolIndex_t'(codeValue - codeThreshold) + codeStart;

endmodule

`default_nettype wire

// ==== hw/hmBitWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmBitWindow import hmCodingPkg::*, hmDatapathPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic loadStrobe,
	input wire logic shiftStrobe,
	input wire bitWindow_t DataIn,
	input wire codeLength_t codeLength,
	input wire nibble_t DhtWidth,
	output codeWord_t windowTop,
	output codeWord_t amplitude
);

	bitWindow_t window;
	codeWord_t rawBits;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			window <= '0;
		end else if (loadStrobe) begin
			window <= DataIn;
		end else if (shiftStrobe) begin
			window <= window << ({1'b0, codeLength} + 5'd1);	// Drop the Huffman code
		end
	end

	assign windowTop = window[WindowWidth-1 -: CodeWidth];

	// Top DhtWidth bits, zero when size is 0
	assign rawBits = windowTop >> (CodeWidth - DhtWidth);

	// Leading 0 means negative magnitude
	assign amplitude = (!windowTop[CodeWidth-1] && DhtWidth != '0) ?
		rawBits - (codeWord_t'(1) << DhtWidth) + codeWord_t'(1) : rawBits;

endmodule

`default_nettype wire

// ==== hw/hmCoefOutput.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmCoefOutput import hmCodingPkg::*, hmDatapathPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic runActive,
	input wire logic valueStrobe,
	input wire logic predictStrobe,
	input wire logic emitStrobe,
	input wire codeWord_t amplitude,
	input wire nibble_t DhtZero,
	input wire nibble_t DhtWidth,
	input wire codeLength_t codeLength,
	input wire logic coefValid,
	input wire blockColor_t blockColor,
	input wire coefIndex_t coefIndex,
	input wire quantStep_t DqtData,
	output useWidth_t DecodeUseWidth,
	output logic DecodeEnable,
	output blockColor_t DecodeColor,
	output coefIndex_t DecodeCount,
	output nibble_t DecodeZero,
	output codeWord_t DecodeCode
);

	codeWord_t ampValue;
	codeWord_t coefValue;
	dcSum_t dcPred [3];	// Y, Cb, Cr
	dcSum_t dcNext;
	logic [1:0] predSel;

	assign predSel = blockColor[2] ? (blockColor[0] ? 2'd2 : 2'd1) : 2'd0;
	assign dcNext = dcPred[predSel] + dcSum_t'($signed(ampValue));

	always_ff @(posedge clk) begin
		if (valueStrobe) ampValue <= amplitude;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dcPred <= '{default: '0};
			coefValue <= '0;
			DecodeZero <= '0;
			DecodeUseWidth <= '0;
		end else begin
			if (valueStrobe) begin
				DecodeZero <= DhtZero;
				DecodeUseWidth <= useWidth_t'(codeLength) + useWidth_t'(DhtWidth) + 7'd1;
			end
			if (!runActive) begin
				dcPred <= '{default: '0};	// New scan
			end else if (predictStrobe) begin
				if (coefIndex == '0) begin
					coefValue <= codeWord_t'(dcNext);
					dcPred[predSel] <= dcNext;
				end else begin
					coefValue <= ampValue;
				end
			end
		end
	end

	assign DecodeEnable = emitStrobe && coefValid;
	assign DecodeColor = blockColor;
	assign DecodeCount = coefIndex;
	assign DecodeCode = codeWord_t'(DqtData * coefValue);	// Low bits keep the sign

endmodule

`default_nettype wire

// ==== hw/hmDecodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmDecodeTop import hmCodingPkg::*, hmDatapathPkg::*; (
	input wire logic clk,
	input wire logic rst,

	// Huffman table load
	input wire logic HuffmanTableEnable,
	input wire tableClass_t HuffmanTableColor,
	input wire codeLength_t HuffmanTableCount,
	input wire codeWord_t HuffmanTableCode,
	input wire symbolIndex_t HuffmanTableStart,

	// Bit stream
	input wire logic DataInRun,
	input wire logic DataInEnable,
	input wire bitWindow_t DataIn,

	// DHT symbol memory
	output tableClass_t DhtColor,
	output symbolIndex_t DhtNumber,
	input wire nibble_t DhtZero,
	input wire nibble_t DhtWidth,

	// DQT memory
	output logic DqtColor,
	output coefIndex_t DqtNumber,
	input wire quantStep_t DqtData,

	input wire logic DataOutIdle,
	output logic DataOutEnable,
	output blockColor_t DataOutColor,

	output logic DecodeUseBit,
	output useWidth_t DecodeUseWidth,
	output logic DecodeEnable,
	output blockColor_t DecodeColor,
	output coefIndex_t DecodeCount,
	output nibble_t DecodeZero,
	output codeWord_t DecodeCode
);

	logic runActive;
	logic loadStrobe, matchStrobe, shiftStrobe;
	logic valueStrobe, predictStrobe, emitStrobe;

	tableClass_t tableClass;
	blockColor_t blockColor;
	coefIndex_t coefIndex;
	logic coefValid;

	codeLength_t codeLength;
	codeWord_t windowTop;
	codeWord_t amplitude;

	assign DhtColor = tableClass;
	assign DqtColor = blockColor[2];	// Luma or chroma quant table
	assign DqtNumber = coefIndex;
	assign DecodeUseBit = predictStrobe;

	hmDecodeFsm fsm (
		.clk, .rst, .DataInRun, .DataInEnable, .DataOutIdle,
		.runActive, .loadStrobe, .matchStrobe, .shiftStrobe,
		.valueStrobe, .predictStrobe, .emitStrobe
	);

	hmCoefCounter counter (
		.clk, .rst, .runActive, .valueStrobe, .emitStrobe, .DhtZero, .DhtWidth,
		.tableClass, .blockColor, .coefIndex, .coefValid, .DataOutEnable, .DataOutColor
	);

	hmCodeTable codeTable (
		.clk, .rst, .HuffmanTableEnable, .HuffmanTableColor, .HuffmanTableCount,
		.HuffmanTableCode, .HuffmanTableStart, .loadStrobe, .matchStrobe, .shiftStrobe,
		.tableClass, .windowTop, .codeLength, .DhtNumber
	);

	hmBitWindow bitWindow (
		.clk, .rst, .loadStrobe, .shiftStrobe, .DataIn, .codeLength, .DhtWidth,
		.windowTop, .amplitude
	);

	hmCoefOutput coefOutput (
		.clk, .rst, .runActive, .valueStrobe, .predictStrobe, .emitStrobe,
		.amplitude, .DhtZero, .DhtWidth, .codeLength, .coefValid, .blockColor,
		.coefIndex, .DqtData, .DecodeUseWidth, .DecodeEnable, .DecodeColor,
		.DecodeCount, .DecodeZero, .DecodeCode
	);

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/hmDecodeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmDecodeTb import hmCodingPkg::*, hmDatapathPkg::*; ();

	localparam int NumRows = 29;
	localparam int SetupCycles = 100;	// Reset and 64 table writes

	logic clk, rst;
	logic HuffmanTableEnable;
	tableClass_t HuffmanTableColor;
	codeLength_t HuffmanTableCount;
	codeWord_t HuffmanTableCode;
	symbolIndex_t HuffmanTableStart;
	logic DataInRun, DataInEnable, DataOutIdle;
	bitWindow_t DataIn;
	tableClass_t DhtColor;
	symbolIndex_t DhtNumber;
	nibble_t DhtZero, DhtWidth;
	logic DqtColor;
	coefIndex_t DqtNumber;
	quantStep_t DqtData;
	logic DataOutEnable, DecodeUseBit, DecodeEnable;
	blockColor_t DataOutColor, DecodeColor;
	useWidth_t DecodeUseWidth;
	coefIndex_t DecodeCount;
	nibble_t DecodeZero;
	codeWord_t DecodeCode;

	typedef struct packed {
		logic [3:0] code;
		logic [2:0] len;
		logic [4:0] amp;
		logic [1:0] stall;
		logic newScan;
		useWidth_t width;
		logic emit;
		coefIndex_t count;
		nibble_t zero;
		codeWord_t value;
		logic outEn;
		blockColor_t outColor;
	} stimRow_t;

	// code, len, amp, stall, newScan | width, emit, count, zero, value, outEn, outColor
	stimRow_t rows [NumRows] = '{
		'{'h5, 3, 'h06, 0, 0, 6, 1, 0, 'h0, 'h0006, 0, 0},	// Y0 DC +6
		'{'h1, 2, 'h00, 1, 0, 3, 1, 1, 'h0, 'hFFFE, 0, 0},
		'{'h4, 3, 'h01, 0, 0, 5, 1, 3, 'h1, 'hFFF8, 0, 0},
		'{'h5, 3, 'h00, 0, 0, 3, 0, 19, 'hF, 'h0000, 0, 0},	// ZRL
		'{'h6, 3, 'h05, 2, 0, 6, 1, 22, 'h2, 'h0073, 0, 0},
		'{'hE, 4, 'h01, 0, 0, 5, 1, 26, 'h3, 'h001B, 0, 0},
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 0},	// EOB
		'{'h0, 2, 'h00, 0, 0, 2, 1, 0, 'h0, 'h0006, 0, 0},
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 1},
		'{'hE, 4, 'h03, 3, 0, 9, 1, 0, 'h0, 'hFFEA, 0, 1},
		'{'h1, 2, 'h01, 0, 0, 3, 1, 1, 'h0, 'h0002, 0, 1},
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 2},
		'{'h1, 2, 'h01, 0, 0, 3, 1, 0, 'h0, 'hFFEB, 0, 2},
		'{'h0, 2, 'h00, 1, 0, 2, 0, 63, 'h0, 'h0000, 1, 3},
		'{'h0, 2, 'h03, 0, 0, 4, 1, 0, 'h0, 'h000F, 0, 3},	// Cb DC
		'{'h5, 3, 'h00, 2, 0, 4, 1, 2, 'h1, 'hFFF9, 0, 3},
		'{'h4, 3, 'h00, 0, 0, 3, 0, 18, 'hF, 'h0000, 0, 3},
		'{'h0, 2, 'h01, 0, 0, 3, 1, 19, 'h0, 'h0018, 0, 3},
		'{'h1, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 4},
		'{'h1, 2, 'h00, 0, 0, 2, 1, 0, 'h0, 'h0000, 0, 4},	// Cr DC
		'{'h6, 3, 'h02, 3, 0, 5, 1, 3, 'h2, 'h0010, 0, 4},
		'{'h1, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 5},
		'{'h4, 3, 'h00, 0, 0, 5, 1, 0, 'h0, 'hFFE8, 0, 5},	// Next MCU
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 0},
		'{'h5, 3, 'h03, 0, 1, 6, 1, 0, 'h0, 'hFFFC, 0, 0},	// Second scan
		'{'hE, 4, 'h00, 1, 0, 5, 1, 4, 'h3, 'hFFFB, 0, 0},
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 0},
		'{'h1, 2, 'h01, 0, 0, 3, 1, 0, 'h0, 'hFFFD, 0, 0},
		'{'h0, 2, 'h00, 0, 0, 2, 0, 63, 'h0, 'h0000, 1, 1}
	};

	// --------------------------------------------------
	// DHT and DQT memory models
	// --------------------------------------------------
	// {run, size} per symbol, tables start at 0, 8, 16, 24
	logic [7:0] symbolMem [32] = '{
		8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h00, 8'h00,
		8'h00, 8'h01, 8'h12, 8'hF0, 8'h23, 8'h31, 8'h00, 8'h00,
		8'h02, 8'h00, 8'h01, 8'h03, 8'h04, 8'h06, 8'h00, 8'h00,
		8'h01, 8'h00, 8'hF0, 8'h11, 8'h22, 8'h32, 8'h00, 8'h00
	};

	assign {DhtZero, DhtWidth} = symbolMem[DhtNumber[4:0]];
	assign DqtData = quantStep_t'(DqtNumber) + 8'd1 + (DqtColor ? 8'd4 : 8'd0);

	tbClock clockGen (.clk, .rst);

	hmDecodeTop i_dut (
		.clk, .rst, .HuffmanTableEnable, .HuffmanTableColor, .HuffmanTableCount,
		.HuffmanTableCode, .HuffmanTableStart, .DataInRun, .DataInEnable, .DataIn,
		.DhtColor, .DhtNumber, .DhtZero, .DhtWidth, .DqtColor, .DqtNumber, .DqtData,
		.DataOutIdle, .DataOutEnable, .DataOutColor, .DecodeUseBit, .DecodeUseWidth,
		.DecodeEnable, .DecodeColor, .DecodeCount, .DecodeZero, .DecodeCode
	);

	int currentRow;
	logic [31:0] rngState = 32'h9c10;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Left-aligned first code per length, same shape in all four tables
	function automatic codeWord_t firstCodeLeft(input int i);
		case (i)
			0, 1: return 16'h0000;
			2: return 16'h8000;
			3: return 16'hE000;
			default: return 16'hFFFF;	// Lengths past 4 never match
		endcase
	endfunction

	function automatic symbolIndex_t firstSymbol(input int c, input int i);
		return symbolIndex_t'(8 * c + ((i == 2) ? 2 : (i == 3) ? 5 : 0));
	endfunction

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic checkCode(input string name, input codeWord_t got, input codeWord_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkIndex(input string name, input coefIndex_t got, input coefIndex_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkColor(input string name, input blockColor_t got, input blockColor_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkClass(input string name, input tableClass_t got, input tableClass_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkWidth(input string name, input useWidth_t got, input useWidth_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkNibble(input string name, input nibble_t got, input nibble_t exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH %s row %0d: got %h, expected %h", name, currentRow, got, exp));
	endtask

	task automatic nextDrivePoint();
		@(posedge clk);
		#1;
	endtask

	task automatic restartScan();
		nextDrivePoint();
		DataInRun = 1'b0;	// FSM drops to idle, predictors clear
		repeat (3) nextDrivePoint();
		DataInRun = 1'b1;
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		stimRow_t row;
		int size;
		int low;
		bitWindow_t window;
		int blockNum;
		logic atBlockStart;
		HuffmanTableEnable = 1'b0;
		HuffmanTableColor = '0;
		HuffmanTableCount = '0;
		HuffmanTableCode = '0;
		HuffmanTableStart = '0;
		DataInRun = 1'b0;
		DataInEnable = 1'b0;
		DataIn = '0;
		DataOutIdle = 1'b1;
		currentRow = 0;
		blockNum = 0;
		atBlockStart = 1'b1;
		@(posedge rst);
		for (int c = 0; c < 4; c++) begin
			for (int i = 0; i < MaxCodeLength; i++) begin
				nextDrivePoint();
				HuffmanTableEnable = 1'b1;
				HuffmanTableColor = tableClass_t'(c);
				HuffmanTableCount = codeLength_t'(i);
				HuffmanTableCode = firstCodeLeft(i);
				HuffmanTableStart = firstSymbol(c, i);
			end
		end
		nextDrivePoint();
		HuffmanTableEnable = 1'b0;
		DataInRun = 1'b1;
		for (int r = 0; r < NumRows; r++) begin
			row = rows[r];
			currentRow = r;
			if (row.newScan) begin
				restartScan();
				blockNum = 0;	// Scan starts at Y0
				atBlockStart = 1'b1;
			end
			size = row.width - row.len;
			low = 32 - row.len - size;
			rngState = xorshift(rngState);
			window = (32'(row.code) << (32 - row.len)) | (32'(row.amp) << low) |
				(rngState & ((32'h1 << low) - 32'h1));
			nextDrivePoint();
			DataIn = window;
			DataInEnable = 1'b1;
			DataOutIdle = (row.stall == 0);
			if (row.stall != 0) begin
				repeat (row.stall) nextDrivePoint();	// Stall in fetch
				DataOutIdle = 1'b1;
				nextDrivePoint();
				DataOutIdle = 1'b0;	// Then again toward lookup
				repeat (row.stall) nextDrivePoint();
				DataOutIdle = 1'b1;
			end
			do @(negedge clk); while (!DecodeUseBit);
			checkWidth("DecodeUseWidth", DecodeUseWidth, row.width);
			// Chroma from block 4 on, AC after the first symbol
			checkClass("DhtColor", DhtColor, tableClass_t'({blockNum >= 4, !atBlockStart}));
			nextDrivePoint();
			DataInEnable = 1'b0;
			@(negedge clk);	// Emit cycle
			if (row.emit && !DecodeEnable)
				abortRun($sformatf("Row %0d expected a coefficient but none was emitted", r));
			if (!row.emit && DecodeEnable)
				abortRun($sformatf("Row %0d emitted a coefficient that was not expected", r));
			checkIndex("DecodeCount", DecodeCount, row.count);
			checkNibble("DecodeZero", DecodeZero, row.zero);
			checkColor("DecodeColor", DecodeColor, blockColor_t'(blockNum));
			if (row.emit) checkCode("DecodeCode", DecodeCode, row.value);
			checkFlag("DataOutEnable", DataOutEnable, row.outEn);
			@(negedge clk);
			checkColor("DataOutColor", DataOutColor, row.outColor);
			if (row.outEn) blockNum = (blockNum + 1) % BlocksPerMcu;
			atBlockStart = row.outEn;
		end
		$display("=== PASS ===");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		int budget;
		budget = SetupCycles;
		for (int r = 0; r < NumRows; r++) begin
			budget += 20 + rows[r].stall + (rows[r].newScan ? 4 : 0);
		end
		repeat (budget) @(posedge clk);
		abortRun("Watchdog expired before all rows were decoded");
	end

endmodule

`default_nettype wire

// ==== all.f ====
hw/hmCodingPkg.sv
hw/hmDatapathPkg.sv
hw/hmDecodeFsm.sv
hw/hmCoefCounter.sv
hw/hmCodeTable.sv
hw/hmBitWindow.sv
hw/hmCoefOutput.sv
hw/hmDecodeTop.sv
verification/tbClock.sv
verification/hmDecodeTb.sv
